/* hw/udp_echo_pkg.sv */
/*
 * UDP echo shared definitions
 * Header and payload beat structs, the answered port and the FIFO depths
 */
package udp_echo_pkg;

    // Port that gets a reply
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Reply headers held while payload drains
    localparam int HDR_DEPTH = 4;

    // Payload beats held in the echo buffer
    localparam int PAY_DEPTH = 64;

    // Received header fields that the reply needs
    typedef struct packed {
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_rx_hdr_t;

    // Varying fields of an outgoing reply header
    typedef struct packed {
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_tx_hdr_t;

    // One 64-bit payload beat
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;   // error flag from upstream
    } pay_beat_t;

endpackage

/* hw/stream_fifo.sv */
/*
 * Valid/ready FIFO
 * Circular buffer with a registered head item, item type set by parameter
 */
`timescale 1ns/100ps

module stream_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_item,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_item
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  rd_next;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign rd_next   = ptr_inc(rd_ptr);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= rd_next;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    // Head register takes the pushed item when the FIFO is or becomes empty
    always_ff @(posedge clk) begin
        if (push && (count == '0 || (pop && count == CNT_W'(1)))) begin
            out_item <= in_item;
        end else if (pop && count > CNT_W'(1)) begin
            out_item <= mem[rd_next];
        end
    end

endmodule

/* hw/port_filter.sv */
/*
 * UDP port filter
 * Matches the destination port, forms the reply header and passes
 * or drops the frame payload
 */
`timescale 1ns/100ps

module port_filter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::udp_rx_hdr_t rx_hdr,
    input  logic                     rx_pay_valid,
    output logic                     rx_pay_ready,
    input  udp_echo_pkg::pay_beat_t  rx_pay,
    output logic                     hdr_out_valid,
    input  logic                     hdr_out_ready,
    output udp_echo_pkg::udp_tx_hdr_t hdr_out,
    output logic                     pay_out_valid,
    input  logic                     pay_out_ready,
    output udp_echo_pkg::pay_beat_t  pay_out
);

    import udp_echo_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_PASS = 2'd1,
        ST_DROP = 2'd2
    } state_t;

    state_t state;
    logic   match;
    logic   hdr_xfer;
    logic   last_xfer;

    assign match = (rx_hdr.dst_port == ECHO_PORT);

    // Header side works only while no frame is open
    assign hdr_out_valid = (state == ST_IDLE) && rx_hdr_valid && match;
    assign rx_hdr_ready  = (state == ST_IDLE) && (!(rx_hdr_valid && match) || hdr_out_ready);
    assign hdr_xfer      = rx_hdr_valid && rx_hdr_ready;

    // Reply swaps the endpoints and keeps the length
    always_comb begin
        hdr_out.dst_ip   = rx_hdr.src_ip;
        hdr_out.src_port = rx_hdr.dst_port;
        hdr_out.dst_port = rx_hdr.src_port;
        hdr_out.length   = rx_hdr.length;
    end

    // Payload side gated by the open frame
    assign pay_out       = rx_pay;
    assign pay_out_valid = (state == ST_PASS) && rx_pay_valid;
    assign rx_pay_ready  = ((state == ST_PASS) && pay_out_ready) || (state == ST_DROP);
    assign last_xfer     = rx_pay_valid && rx_pay_ready && rx_pay.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= match ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (last_xfer) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* hw/led_capture.sv */
/*
 * LED capture
 * Shows the low byte of the first beat of every outgoing frame
 */
`timescale 1ns/100ps

module led_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    beat_valid,
    input  logic                    beat_ready,
    input  udp_echo_pkg::pay_beat_t beat,
    output logic [7:0]              led
);

    logic first;
    logic xfer;

    assign xfer = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first <= 1'b1;
            led   <= 8'h00;
        end else if (xfer) begin
            // Next beat starts a frame once this one closes it
            first <= beat.last;
            if (first) begin
                led <= beat.data[7:0];
            end
        end
    end

endmodule

/* hw/udp_echo_core.sv */
/*
 * UDP echo responder core
 * Filters received frames, queues reply headers and echoed payload,
 * and shows the first payload byte on the LEDs
 */
`timescale 1ns/100ps

module udp_echo_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::udp_rx_hdr_t rx_hdr,
    input  logic                      rx_pay_valid,
    output logic                      rx_pay_ready,
    input  udp_echo_pkg::pay_beat_t   rx_pay,
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::udp_tx_hdr_t tx_hdr,
    output logic                      tx_pay_valid,
    input  logic                      tx_pay_ready,
    output udp_echo_pkg::pay_beat_t   tx_pay,
    output logic [7:0]                led
);

    import udp_echo_pkg::*;

    // Filter to FIFO streams
    logic        flt_hdr_valid;
    logic        flt_hdr_ready;
    udp_tx_hdr_t flt_hdr;
    logic        flt_pay_valid;
    logic        flt_pay_ready;
    pay_beat_t   flt_pay;

    port_filter u_filter (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_hdr        (rx_hdr),
        .rx_pay_valid  (rx_pay_valid),
        .rx_pay_ready  (rx_pay_ready),
        .rx_pay        (rx_pay),
        .hdr_out_valid (flt_hdr_valid),
        .hdr_out_ready (flt_hdr_ready),
        .hdr_out       (flt_hdr),
        .pay_out_valid (flt_pay_valid),
        .pay_out_ready (flt_pay_ready),
        .pay_out       (flt_pay)
    );

    // Headers may run ahead of the payload of earlier frames
    stream_fifo #(
        .item_t (udp_tx_hdr_t),
        .DEPTH  (HDR_DEPTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (flt_hdr_valid),
        .in_ready  (flt_hdr_ready),
        .in_item   (flt_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready),
        .out_item  (tx_hdr)
    );

    stream_fifo #(
        .item_t (pay_beat_t),
        .DEPTH  (PAY_DEPTH)
    ) u_pay_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (flt_pay_valid),
        .in_ready  (flt_pay_ready),
        .in_item   (flt_pay),
        .out_valid (tx_pay_valid),
        .out_ready (tx_pay_ready),
        .out_item  (tx_pay)
    );

    led_capture u_led (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (tx_pay_valid),
        .beat_ready (tx_pay_ready),
        .beat       (tx_pay),
        .led        (led)
    );

endmodule

/* tests/udp_echo_chk.sv */
/*
 * Port filter protocol checks
 * Output hold rules and the frame gating of both ready signals
 */
`timescale 1ns/100ps

module udp_echo_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      rx_hdr_valid,
    input logic                      rx_hdr_ready,
    input logic                      rx_pay_valid,
    input logic                      rx_pay_ready,
    input logic                      rx_pay_last,
    input logic                      hdr_out_valid,
    input logic                      hdr_out_ready,
    input udp_echo_pkg::udp_tx_hdr_t hdr_out,
    input logic                      pay_out_valid,
    input logic                      pay_out_ready,
    input udp_echo_pkg::pay_beat_t   pay_out
);

    int   fails = 0;
    logic frame_open;

    // Open frame as seen from the rx handshakes alone
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
        end else if (!frame_open) begin
            frame_open <= rx_hdr_valid && rx_hdr_ready;
        end else if (rx_pay_valid && rx_pay_ready && rx_pay_last) begin
            frame_open <= 1'b0;
        end
    end

    // A stalled reply header keeps its fields
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        hdr_out_valid && !hdr_out_ready |=> hdr_out_valid && $stable(hdr_out))
        else begin
            $error("hdr_out changed before its handshake");
            fails++;
        end

    a_pay_hold: assert property (@(posedge clk) disable iff (rst)
        pay_out_valid && !pay_out_ready |=> pay_out_valid && $stable(pay_out))
        else begin
            $error("pay_out changed before its handshake");
            fails++;
        end

    // One frame at a time
    a_hdr_gate: assert property (@(posedge clk) disable iff (rst)
        frame_open |-> !rx_hdr_ready)
        else begin
            $error("rx_hdr_ready high while a frame is open");
            fails++;
        end

    a_pay_gate: assert property (@(posedge clk) disable iff (rst)
        !frame_open |-> !rx_pay_ready)
        else begin
            $error("rx_pay_ready high while no frame is open");
            fails++;
        end

endmodule

bind port_filter udp_echo_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .rx_hdr_valid  (rx_hdr_valid),
    .rx_hdr_ready  (rx_hdr_ready),
    .rx_pay_valid  (rx_pay_valid),
    .rx_pay_ready  (rx_pay_ready),
    .rx_pay_last   (rx_pay.last),
    .hdr_out_valid (hdr_out_valid),
    .hdr_out_ready (hdr_out_ready),
    .hdr_out       (hdr_out),
    .pay_out_valid (pay_out_valid),
    .pay_out_ready (pay_out_ready),
    .pay_out       (pay_out)
);

/* tests/udp_echo_tb.sv */
/*
 * UDP echo core testbench
 * Directed frames with random payload and back-pressure, checked
 * against a reference queue of reply headers and echoed beats
 */
`timescale 1ns/100ps

module udp_echo_tb;

    import udp_echo_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int RAND_FRAMES = 40;
    localparam int MAX_BEATS   = 8;
    localparam int TOTAL_BEATS = RAND_FRAMES * MAX_BEATS + 4 * (HDR_DEPTH + 1) + 16;
    localparam int CYCLE_LIMIT = RST_CYCLES + 8 * TOTAL_BEATS + 400;

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    udp_rx_hdr_t rx_hdr;
    logic        rx_pay_valid;
    logic        rx_pay_ready;
    pay_beat_t   rx_pay;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    udp_tx_hdr_t tx_hdr;
    logic        tx_pay_valid;
    logic        tx_pay_ready;
    pay_beat_t   tx_pay;
    logic [7:0]  led;

    udp_tx_hdr_t exp_hdr[$];
    pay_beat_t   exp_pay[$];
    logic [31:0] rng_state;
    logic [31:0] rng_rdy;
    logic        rand_ready;
    logic        first_beat;
    logic        led_due;
    logic [7:0]  led_exp;
    int          errors;
    int          checks;
    int          cycles;
    int          assert_fails;

    udp_echo_core u_udp_echo_core (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Random tx back-pressure
    always @(negedge clk) begin
        if (rand_ready) begin
            rng_rdy = xorshift(rng_rdy);
            tx_hdr_ready = rng_rdy[3];
            tx_pay_ready = rng_rdy[9] | rng_rdy[17];
        end
    end

    // Collector compares every tx handshake with the reference queues
    always @(posedge clk) begin : collect
        udp_tx_hdr_t h;
        pay_beat_t   b;
        if (!rst) begin
            if (led_due) begin
                check_value("led after frame", 128'(led), 128'(led_exp));
                led_due = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    errors++;
                    $display("A reply header left the core at %0t with none expected", $time);
                end else begin
                    h = exp_hdr.pop_front();
                    check_value("tx_hdr", 128'(tx_hdr), 128'(h));
                end
            end
            if (tx_pay_valid && tx_pay_ready) begin
                if (exp_pay.size() == 0) begin
                    errors++;
                    $display("A payload beat left the core at %0t with none expected", $time);
                end else begin
                    b = exp_pay.pop_front();
                    check_value("tx_pay", 128'(tx_pay), 128'(b));
                    if (first_beat) begin
                        led_exp = b.data[7:0];
                    end
                    first_beat = b.last;
                    led_due = b.last;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped moving data", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Drives one frame and can check a header stall before tx_hdr_ready goes high
    task automatic send_frame(input logic [15:0] dst_port, input int nbeats,
                              input int hold_cycles);
        udp_rx_hdr_t h;
        udp_tx_hdr_t t;
        pay_beat_t   b;
        logic [31:0] r;
        logic        match;
        r = next_rand();
        h.src_ip   = next_rand();
        h.src_port = r[15:0];
        h.dst_port = dst_port;
        h.length   = 16'(8 + 8 * nbeats);
        match = (dst_port == ECHO_PORT);
        if (match) begin
            t.dst_ip   = h.src_ip;
            t.src_port = h.dst_port;
            t.dst_port = h.src_port;
            t.length   = h.length;
            exp_hdr.push_back(t);
        end
        rx_hdr = h;
        rx_hdr_valid = 1'b1;
        repeat (hold_cycles) begin
            @(posedge clk);
            check_value("rx_hdr_ready with header FIFO full", 128'(rx_hdr_ready), 128'(1'b0));
        end
        if (hold_cycles > 0) begin
            @(negedge clk);
            tx_hdr_ready = 1'b1;
        end
        do @(posedge clk); while (!rx_hdr_ready);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            r = next_rand();
            b.data = {next_rand(), r};
            b.last = (i == nbeats - 1);
            b.keep = b.last ? (8'hff >> r[2:0]) : 8'hff;
            b.user = r[8] & r[9];
            if (match) begin
                exp_pay.push_back(b);
            end
            rx_pay = b;
            rx_pay_valid = 1'b1;
            do @(posedge clk); while (!rx_pay_ready);
            @(negedge clk);
        end
        rx_pay_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_hdr.size() != 0 || exp_pay.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic echo_one_frame();
        check_value("led after reset", 128'(led), 128'(8'h00));
        check_value("tx_hdr_valid after reset", 128'(tx_hdr_valid), 128'(1'b0));
        check_value("tx_pay_valid after reset", 128'(tx_pay_valid), 128'(1'b0));
        check_value("rx_hdr_ready after reset", 128'(rx_hdr_ready), 128'(1'b1));
        check_value("rx_pay_ready after reset", 128'(rx_pay_ready), 128'(1'b0));
        send_frame(ECHO_PORT, 3, 0);
        wait_drain();
    endtask

    task automatic drop_other_port();
        send_frame(16'd80, 4, 0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("led after dropped frame", 128'(led), 128'(led_exp));
        send_frame(ECHO_PORT, 2, 0);
        wait_drain();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        rand_ready = 1'b1;
        repeat (RAND_FRAMES) begin
            r = next_rand();
            send_frame(r[0] ? ECHO_PORT : 16'd5000 + 16'(r[11:4]), int'(r[3:1]) + 1, 0);
        end
        wait_drain();
        rand_ready = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_pay_ready = 1'b1;
    endtask

    task automatic fill_hdr_fifo();
        tx_hdr_ready = 1'b0;
        tx_pay_ready = 1'b1;
        repeat (HDR_DEPTH) send_frame(ECHO_PORT, 1, 0);
        send_frame(ECHO_PORT, 1, 20);
        wait_drain();
    endtask

    initial begin
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_hdr       = '0;
        rx_pay_valid = 1'b0;
        rx_pay       = '0;
        tx_hdr_ready = 1'b1;
        tx_pay_ready = 1'b1;
        rand_ready   = 1'b0;
        rng_state    = 32'he3a6;
        rng_rdy      = ~32'he3a6;
        first_beat   = 1'b1;
        led_due      = 1'b0;
        led_exp      = 8'h00;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        echo_one_frame();
        drop_other_port();
        random_traffic();
        fill_hdr_fifo();
        assert_fails = u_udp_echo_core.u_filter.u_chk.fails;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
hw/udp_echo_pkg.sv
hw/stream_fifo.sv
hw/port_filter.sv
hw/led_capture.sv
hw/udp_echo_core.sv
tests/udp_echo_chk.sv
tests/udp_echo_tb.sv

/* Makefile */
# Verilator simulation of the UDP echo core

VERILATOR ?= verilator
TOP       ?= udp_echo_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
